// File: bench/proc_testdata.txt
# tag value: i = program word from reset_pc upward, s = manager input word,
# e = expected manager output word, all values in hex
# echo two manager words
i fc0020f3  # csrr x1
i 7c009073  # csrw x1
i fc002173  # csrr x2
i 7c011073  # csrw x2
# operands a in x1, b in x2
i fc0020f3  # csrr x1
i fc002173  # csrr x2
i 002081b3  # add x3, x1, x2
i 7c019073  # csrw x3
i 402081b3  # sub x3, x1, x2
i 7c019073  # csrw x3
i 0020f1b3  # and x3, x1, x2
i 7c019073  # csrw x3
i 0020e1b3  # or x3, x1, x2
i 7c019073  # csrw x3
i 0020c1b3  # xor x3, x1, x2
i 7c019073  # csrw x3
i 0020a1b3  # slt x3, x1, x2
i 7c019073  # csrw x3
i 0020b1b3  # sltu x3, x1, x2
i 7c019073  # csrw x3
i 4020d1b3  # sra x3, x1, x2
i 7c019073  # csrw x3
i 0020d1b3  # srl x3, x1, x2
i 7c019073  # csrw x3
i 002091b3  # sll x3, x1, x2
i 7c019073  # csrw x3
i 001131b3  # sltu x3, x2, x1
i 7c019073  # csrw x3
i ffb08193  # addi x3, x1, -5
i 7c019073  # csrw x3
# dependent chain
i 00710213  # addi x4, x2, 7
i 004202b3  # add x5, x4, x4
i 40128333  # sub x6, x5, x1
i 7c031073  # csrw x6
# taken bne skips two csrw, not-taken bne falls through
i 00100393  # addi x7, x0, 1
i 00039663  # bne x7, x0, +12
i 7c009073  # csrw x1, skipped
i 7c011073  # csrw x2, skipped
i 7c039073  # csrw x7
i 00001463  # bne x0, x0, +8
i 7c021073  # csrw x4
i 00039063  # bne x7, x0, 0 spins here
s 13579bdf
s fedcba98
s 80000010  # a
s 00000014  # b, shift amount 20
e 13579bdf
e fedcba98
e 80000024  # add
e 7ffffffc  # sub
e 00000010  # and
e 80000014  # or
e 80000004  # xor
e 00000001  # slt, a is negative
e 00000000  # sltu
e fffff800  # sra
e 00000800  # srl
e 01000000  # sll
e 00000001  # sltu b < a
e 8000000b  # addi
e 80000026  # chain
e 00000001  # after taken bne
e 0000001b  # after not-taken bne

// File: files.f
verilog/proc_pkg.sv
verilog/proc_alu.sv
verilog/proc_regfile.sv
verilog/proc_ctrl.sv
verilog/proc_dpath.sv
verilog/proc_top.sv
bench/proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the processor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -f files.f --top-module proc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vproc_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1

// File: bench/proc_tb.sv
//----------------------------------------------------------
// testbench for proc_top that loads program and streams from
// the data file and runs once unstalled and once with random val/rdy
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_tb;

  localparam proc_pkg::word_t reset_pc = 32'h200;
  localparam int mem_words    = 256;
  localparam int num_passes   = 2;
  localparam int drain_cycles = 20;

  logic            clk = 1'b0;
  logic            reset;
  proc_pkg::word_t imem_addr;
  proc_pkg::word_t imem_data;
  logic            mngr2proc_val;
  logic            mngr2proc_rdy;
  proc_pkg::word_t mngr2proc_data;
  logic            proc2mngr_val;
  logic            proc2mngr_rdy;
  proc_pkg::word_t proc2mngr_data;

  // program image and the two manager streams
  proc_pkg::word_t imem [mem_words];
  proc_pkg::word_t src_q [$];
  proc_pkg::word_t exp_q [$];
  int              num_words = 0;

  int seed;
  int value_errors = 0;
  int other_errors = 0;
  int checks       = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;
  int src_idx      = 0;
  int out_idx      = 0;

  proc_top #(
    .reset_pc (reset_pc)
  ) dut (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .mngr2proc_val  (mngr2proc_val),
    .mngr2proc_rdy  (mngr2proc_rdy),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_val  (proc2mngr_val),
    .proc2mngr_rdy  (proc2mngr_rdy),
    .proc2mngr_data (proc2mngr_data)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // watchdog over both passes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d outputs seen in the current pass",
               cycle_count, out_idx);
      $display(">>> FAIL");
      $finish;
    end
  end

  // unloaded words end in 2'b00 where every kept opcode ends in 2'b11
  // so D decodes them as bubbles
  function automatic proc_pkg::word_t fill_word(input proc_pkg::word_t addr);
    return {addr[31:2] ^ 30'h2a5b947a, 2'b00};
  endfunction

  function automatic proc_pkg::word_t read_imem(input proc_pkg::word_t addr);
    proc_pkg::word_t offset;
    offset = (addr - reset_pc) >> 2;
    if (addr >= reset_pc && offset < 32'(mem_words)) begin
      return imem[offset];
    end else begin
      return fill_word(addr);
    end
  endfunction

  function automatic logic coin_flip();
    return 1'($random(seed));
  endfunction

  task automatic load_program_file();
    int              fd;
    int              code;
    int              i;
    string           line;
    logic [7:0]      tag;
    proc_pkg::word_t value;
    for (i = 0; i < mem_words; i++) begin
      imem[i] = fill_word(reset_pc + 32'(i * 4));
    end
    fd = $fopen("bench/proc_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/proc_testdata.txt, nothing to run");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // comment lines start with # and fall through every tag test
        if (code > 0 && $sscanf(line, "%c %h", tag, value) == 2) begin
          if (tag == "i") begin
            if (num_words < mem_words) begin
              imem[num_words] = value;
            end else begin
              $display("program has more than %0d words, the rest is dropped", mem_words);
              other_errors++;
            end
            num_words++;
          end else if (tag == "s") begin
            src_q.push_back(value);
          end else if (tag == "e") begin
            exp_q.push_back(value);
          end
        end
      end
      $fclose(fd);
    end
    if (exp_q.size() == 0) begin
      $display("data file lists no expected outputs");
      other_errors++;
    end
    cycle_limit = num_passes * (60 * num_words + 200);
  endtask

  task automatic check_word(input proc_pkg::word_t got, input proc_pkg::word_t expected,
                            input int idx);
    checks++;
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: output %0d is %h, expected %h",
               $time, idx, got, expected);
      value_errors++;
    end
  endtask

  task automatic record_output(input proc_pkg::word_t data);
    if (out_idx < exp_q.size()) begin
      check_word(data, exp_q[out_idx], out_idx);
    end else begin
      $display("extra output word %h at %0t, all %0d expected words already arrived",
               data, $time, exp_q.size());
      other_errors++;
    end
    out_idx++;
  endtask

  // manager input holds val until taken and rdy is redrawn each cycle
  task automatic update_streams(input bit random_hs, input bit taken);
    if (taken || !mngr2proc_val) begin
      if (src_idx < src_q.size()) begin
        mngr2proc_data = src_q[src_idx];
        mngr2proc_val  = random_hs ? coin_flip() : 1'b1;
      end else begin
        mngr2proc_val = 1'b0;
      end
    end
    proc2mngr_rdy = random_hs ? coin_flip() : 1'b1;
  endtask

  task automatic run_pass(input bit random_hs);
    int              idle;
    bit              m_fire;
    bit              p_fire;
    proc_pkg::word_t p_data;
    proc_pkg::word_t fetch_addr;
    reset          = 1'b1;
    imem_data      = '0;
    mngr2proc_val  = 1'b0;
    mngr2proc_data = '0;
    proc2mngr_rdy  = 1'b0;
    src_idx        = 0;
    out_idx        = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    update_streams(random_hs, 1'b0);
    idle = 0;
    while (idle < drain_cycles) begin
      // everything is settled by the falling edge
      @(negedge clk);
      fetch_addr = imem_addr;
      m_fire     = mngr2proc_val && mngr2proc_rdy;
      p_fire     = proc2mngr_val && proc2mngr_rdy;
      p_data     = proc2mngr_data;
      @(posedge clk);
      #1;
      // registered imem read of last cycle's address
      imem_data = read_imem(fetch_addr);
      if (p_fire) begin
        record_output(p_data);
      end
      if (m_fire) begin
        src_idx++;
      end
      update_streams(random_hs, m_fire);
      // keep watching a while for words past the end
      if (out_idx >= exp_q.size()) begin
        idle++;
      end
    end
  endtask

  initial begin
    seed = 32'ha15b947a;
    load_program_file();
    run_pass(1'b0);
    run_pass(1'b1);
    $display("outputs checked %0d of %0d, value errors %0d, other errors %0d",
             checks, num_passes * exp_q.size(), value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/proc_top.sv
//----------------------------------------------------------
// processor top: control, datapath and register file
// reset_pc sets the first fetch address
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_top #(
  parameter proc_pkg::word_t reset_pc = 32'h200
) (
  input  logic            clk,
  input  logic            reset,
  output proc_pkg::word_t imem_addr,
  input  proc_pkg::word_t imem_data,
  input  logic            mngr2proc_val,
  output logic            mngr2proc_rdy,
  input  proc_pkg::word_t mngr2proc_data,
  output logic            proc2mngr_val,
  input  logic            proc2mngr_rdy,
  output proc_pkg::word_t proc2mngr_data
);

  proc_pkg::ctrl_sig_t ctrl;
  proc_pkg::stat_sig_t stat;

  // register file ports
  proc_pkg::reg_addr_t rf_raddr0, rf_raddr1;
  proc_pkg::word_t     rf_rdata0, rf_rdata1, rf_wdata;

  proc_ctrl ctrl_unit (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (ctrl),
    .stat          (stat),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (proc2mngr_val),
    .proc2mngr_rdy (proc2mngr_rdy)
  );

  proc_dpath #(
    .reset_pc (reset_pc)
  ) dpath (
    .clk            (clk),
    .reset          (reset),
    .ctrl           (ctrl),
    .stat           (stat),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .rf_raddr0      (rf_raddr0),
    .rf_raddr1      (rf_raddr1),
    .rf_rdata0      (rf_rdata0),
    .rf_rdata1      (rf_rdata1),
    .rf_wdata       (rf_wdata),
    .mngr2proc_data (mngr2proc_data),
    .proc2mngr_data (proc2mngr_data)
  );

  // write enable and address come from control, data from W
  proc_regfile rf (
    .clk    (clk),
    .raddr0 (rf_raddr0),
    .rdata0 (rf_rdata0),
    .raddr1 (rf_raddr1),
    .rdata1 (rf_rdata1),
    .wen    (ctrl.rf_wen_w),
    .waddr  (ctrl.rf_waddr_w),
    .wdata  (rf_wdata)
  );

endmodule

// File: verilog/proc_dpath.sv
//----------------------------------------------------------
// processor datapath: pc, pipeline data registers, operand
// muxes and branch target; steered by the control struct
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_dpath #(
  parameter proc_pkg::word_t reset_pc = 32'h200
) (
  input  logic                clk,
  input  logic                reset,
  input  proc_pkg::ctrl_sig_t ctrl,
  output proc_pkg::stat_sig_t stat,
  output proc_pkg::word_t     imem_addr,
  input  proc_pkg::word_t     imem_data,
  output proc_pkg::reg_addr_t rf_raddr0,
  output proc_pkg::reg_addr_t rf_raddr1,
  input  proc_pkg::word_t     rf_rdata0,
  input  proc_pkg::word_t     rf_rdata1,
  output proc_pkg::word_t     rf_wdata,
  input  proc_pkg::word_t     mngr2proc_data,
  output proc_pkg::word_t     proc2mngr_data
);

  proc_pkg::word_t pc_f, pc_next, pc_d, pc_x, br_target_x;
  proc_pkg::word_t inst_d, imm_i_d, imm_b_d, op_b_d;
  proc_pkg::word_t op_a_x, op_b_x, imm_x, alu_result_x;
  proc_pkg::word_t result_m, result_w;
  logic            eq_x;

  //----------------------------------------------------------
  // F stage
  //----------------------------------------------------------

  assign br_target_x = pc_x + imm_x;
  assign pc_next     = (ctrl.pc_sel == proc_pkg::pc_br) ? br_target_x : pc_f + 32'd4;

  // imem answers a cycle later, so a stalled F re-presents its own pc
  assign imem_addr = ctrl.reg_en_f ? pc_next : pc_f;

  // one word below reset_pc so the first fetch lands on reset_pc
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= reset_pc - 32'd4;
    end else if (ctrl.reg_en_f) begin
      pc_f <= pc_next;
    end
  end

  //----------------------------------------------------------
  // D stage
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      inst_d <= imem_data;
      pc_d   <= pc_f;
    end
  end

  assign rf_raddr0 = inst_d[19:15];
  assign rf_raddr1 = inst_d[24:20];

  // i-type for addi, b-type for bne
  assign imm_i_d = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_b_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};

  always_comb begin
    case (ctrl.op2_sel_d)
      proc_pkg::op2_imm:  op_b_d = imm_i_d;
      proc_pkg::op2_mngr: op_b_d = mngr2proc_data;
      default:            op_b_d = rf_rdata1;
    endcase
  end

  assign stat.inst_d = inst_d;

  //----------------------------------------------------------
  // X stage
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_x) begin
      pc_x   <= pc_d;
      imm_x  <= imm_b_d;
      op_a_x <= rf_rdata0;
      op_b_x <= op_b_d;
    end
  end

  proc_alu alu (
    .op_a   (op_a_x),
    .op_b   (op_b_x),
    .fn     (ctrl.alu_fn_x),
    .result (alu_result_x),
    .eq     (eq_x)
  );

  assign stat.br_cond_eq_x = eq_x;

  //----------------------------------------------------------
  // M and W stages
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_m) begin
      result_m <= alu_result_x;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_w) begin
      result_w <= result_m;
    end
  end

  // same word feeds writeback and the manager output
  assign rf_wdata       = result_w;
  assign proc2mngr_data = result_w;

endmodule

// File: verilog/proc_ctrl.sv
//----------------------------------------------------------
// pipeline control: valid bits, decode, hazards, stall/squash
// drives the datapath selects and the manager val/rdy outputs
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_ctrl (
  input  logic                clk,
  input  logic                reset,
  output proc_pkg::ctrl_sig_t ctrl,
  input  proc_pkg::stat_sig_t stat,
  input  logic                mngr2proc_val,
  output logic                mngr2proc_rdy,
  output logic                proc2mngr_val,
  input  logic                proc2mngr_rdy
);

  // stage valid bits, bubbles are val low
  logic val_f, val_d, val_x, val_m, val_w;

  // ostall is raised by a stage, stall includes stages ahead
  logic ostall_d, ostall_w;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic squash_f, squash_d;
  logic osquash_x;

  // per-stage control registers
  logic                rf_wen_x, rf_wen_m, rf_wen_pend_w;
  proc_pkg::reg_addr_t rf_waddr_x, rf_waddr_m, rf_waddr_w;
  proc_pkg::alu_fn_e   alu_fn_x;
  proc_pkg::br_type_e  br_type_x;
  logic                p2m_x, p2m_m, p2m_w;

  //----------------------------------------------------------
  // F stage
  //----------------------------------------------------------

  // a squash overrides the stall so the redirect gets fetched
  assign ctrl.reg_en_f = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (ctrl.reg_en_f) begin
      val_f <= 1'b1;
    end
  end

  // redirect only once the branch actually leaves X
  assign ctrl.pc_sel = osquash_x ? proc_pkg::pc_br : proc_pkg::pc_plus4;

  assign stall_f  = val_f && (ostall_d || ostall_w);
  assign squash_f = val_f && osquash_x;

  logic next_val_f;
  assign next_val_f = val_f && !stall_f && !squash_f;

  //----------------------------------------------------------
  // D stage
  //----------------------------------------------------------

  assign ctrl.reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (ctrl.reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  // instruction fields
  proc_pkg::reg_addr_t rs1_d, rs2_d, rd_d;
  proc_pkg::csr_addr_t csr_d;

  assign rs1_d = stat.inst_d[19:15];
  assign rs2_d = stat.inst_d[24:20];
  assign rd_d  = stat.inst_d[11:7];
  assign csr_d = stat.inst_d[31:20];

  // decoded control word
  typedef struct packed {
    logic               inst_val;
    proc_pkg::br_type_e br_type;
    proc_pkg::op2_sel_e op2_sel;
    logic               rs1_en;
    logic               rs2_en;
    proc_pkg::alu_fn_e  alu_fn;
    logic               rf_wen;
    logic               csrr;
    logic               csrw;
  } dec_t;

  localparam logic y = 1'b1;
  localparam logic n = 1'b0;

  // encodings, ? marks register and immediate fields
  localparam logic [31:0] inst_add  = 32'b0000000_?????_?????_000_?????_0110011;
  localparam logic [31:0] inst_sub  = 32'b0100000_?????_?????_000_?????_0110011;
  localparam logic [31:0] inst_sll  = 32'b0000000_?????_?????_001_?????_0110011;
  localparam logic [31:0] inst_slt  = 32'b0000000_?????_?????_010_?????_0110011;
  localparam logic [31:0] inst_sltu = 32'b0000000_?????_?????_011_?????_0110011;
  localparam logic [31:0] inst_xor  = 32'b0000000_?????_?????_100_?????_0110011;
  localparam logic [31:0] inst_srl  = 32'b0000000_?????_?????_101_?????_0110011;
  localparam logic [31:0] inst_sra  = 32'b0100000_?????_?????_101_?????_0110011;
  localparam logic [31:0] inst_or   = 32'b0000000_?????_?????_110_?????_0110011;
  localparam logic [31:0] inst_and  = 32'b0000000_?????_?????_111_?????_0110011;
  localparam logic [31:0] inst_addi = 32'b???????_?????_?????_000_?????_0010011;
  localparam logic [31:0] inst_bne  = 32'b???????_?????_?????_001_?????_1100011;
  // csrr is csrrs rd, csr, x0 and csrw is csrrw x0, csr, rs1
  localparam logic [31:0] inst_csrr = 32'b???????_?????_00000_010_?????_1110011;
  localparam logic [31:0] inst_csrw = 32'b???????_?????_?????_001_00000_1110011;

  dec_t cs;

  // columns: val, branch, op2, rs1 en, rs2 en, alu fn, rf wen, csrr, csrw
  always_comb begin
    casez (stat.inst_d)
      inst_add:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_add, y, n, n};
      inst_sub:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_sub, y, n, n};
      inst_and:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_and, y, n, n};
      inst_or:   cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_or, y, n, n};
      inst_xor:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_xor, y, n, n};
      inst_slt:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_slt, y, n, n};
      inst_sltu: cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_sltu, y, n, n};
      inst_sra:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_sra, y, n, n};
      inst_srl:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_srl, y, n, n};
      inst_sll:  cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, y, proc_pkg::alu_sll, y, n, n};
      inst_addi: cs = '{y, proc_pkg::br_none, proc_pkg::op2_imm, y, n, proc_pkg::alu_add, y, n, n};
      // equality comes from the alu compare, the alu result is unused
      inst_bne:  cs = '{y, proc_pkg::br_bne, proc_pkg::op2_rf, y, y, proc_pkg::alu_sub, n, n, n};
      inst_csrr: cs = '{y, proc_pkg::br_none, proc_pkg::op2_mngr, n, n, proc_pkg::alu_cp1, y, y, n};
      // csr 0x7c0 leaves x0 in the rs2 field, so rs1 + x0 carries rs1 through
      inst_csrw: cs = '{y, proc_pkg::br_none, proc_pkg::op2_rf, y, n, proc_pkg::alu_add, n, n, y};
      default:   cs = '{n, proc_pkg::br_none, proc_pkg::op2_rf, n, n, proc_pkg::alu_add, n, n, n};
    endcase
  end

  assign ctrl.op2_sel_d = cs.op2_sel;

  // manager channel matching on the csr number
  logic mngr2proc_d, proc2mngr_d;
  assign mngr2proc_d = cs.csrr && (csr_d == proc_pkg::csr_mngr2proc);
  assign proc2mngr_d = cs.csrw && (csr_d == proc_pkg::csr_proc2mngr);

  // raw hazard against one pending write, x0 never conflicts
  function automatic logic raw_hit(input proc_pkg::reg_addr_t src, input logic v,
                                   input logic wen, input proc_pkg::reg_addr_t waddr);
    return v && wen && (waddr != 5'd0) && (src == waddr);
  endfunction

  // no bypassing, so wait until the writer has left W
  logic raw_rs1_d, raw_rs2_d, ostall_mngr_d;

  assign raw_rs1_d = cs.rs1_en && (raw_hit(rs1_d, val_x, rf_wen_x, rf_waddr_x)
                                || raw_hit(rs1_d, val_m, rf_wen_m, rf_waddr_m)
                                || raw_hit(rs1_d, val_w, rf_wen_pend_w, rf_waddr_w));
  assign raw_rs2_d = cs.rs2_en && (raw_hit(rs2_d, val_x, rf_wen_x, rf_waddr_x)
                                || raw_hit(rs2_d, val_m, rf_wen_m, rf_waddr_m)
                                || raw_hit(rs2_d, val_w, rf_wen_pend_w, rf_waddr_w));

  assign ostall_mngr_d = mngr2proc_d && !mngr2proc_val;
  assign ostall_d      = val_d && (ostall_mngr_d || raw_rs1_d || raw_rs2_d);

  assign stall_d  = val_d && (ostall_d || ostall_w);
  assign squash_d = val_d && osquash_x;

  // ready does not look at mngr2proc_val, only at the other stall causes
  assign mngr2proc_rdy = val_d && mngr2proc_d && !raw_rs1_d && !raw_rs2_d
                      && !ostall_w && !squash_d;

  // an illegal encoding leaves D as a bubble
  logic next_val_d;
  assign next_val_d = val_d && !stall_d && !squash_d && cs.inst_val;

  //----------------------------------------------------------
  // X stage
  //----------------------------------------------------------

  assign ctrl.reg_en_x = !stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (ctrl.reg_en_x) begin
      val_x      <= next_val_d;
      rf_wen_x   <= cs.rf_wen;
      rf_waddr_x <= rd_d;
      alu_fn_x   <= cs.alu_fn;
      br_type_x  <= cs.br_type;
      p2m_x      <= proc2mngr_d;
    end
  end

  assign ctrl.alu_fn_x = alu_fn_x;

  assign stall_x = val_x && ostall_w;

  // taken bne squashes F and D, held back while X itself stalls
  assign osquash_x = val_x && !stall_x && (br_type_x == proc_pkg::br_bne)
                  && !stat.br_cond_eq_x;

  logic next_val_x;
  assign next_val_x = val_x && !stall_x;

  //----------------------------------------------------------
  // M stage, a plain register stage
  //----------------------------------------------------------

  assign ctrl.reg_en_m = !stall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (ctrl.reg_en_m) begin
      val_m      <= next_val_x;
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      p2m_m      <= p2m_x;
    end
  end

  assign stall_m = val_m && ostall_w;

  logic next_val_m;
  assign next_val_m = val_m && !stall_m;

  //----------------------------------------------------------
  // W stage
  //----------------------------------------------------------

  assign ctrl.reg_en_w = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (ctrl.reg_en_w) begin
      val_w         <= next_val_m;
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
      p2m_w         <= p2m_m;
    end
  end

  // csrw waits here for the manager to take the word
  assign ostall_w = val_w && p2m_w && !proc2mngr_rdy;

  // nothing sits ahead of W
  assign stall_w = ostall_w;

  assign ctrl.rf_wen_w   = val_w && rf_wen_pend_w;
  assign ctrl.rf_waddr_w = rf_waddr_w;

  // val is raised without waiting for rdy
  assign proc2mngr_val = val_w && p2m_w;

endmodule

// File: verilog/proc_regfile.sv
//----------------------------------------------------------
// 32 x 32 register file, two async reads, one sync write
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_regfile (
  input  logic                clk,
  input  proc_pkg::reg_addr_t raddr0,
  output proc_pkg::word_t     rdata0,
  input  proc_pkg::reg_addr_t raddr1,
  output proc_pkg::word_t     rdata1,
  input  logic                wen,
  input  proc_pkg::reg_addr_t waddr,
  input  proc_pkg::word_t     wdata
);

  proc_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired on the read side
  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

endmodule

// File: verilog/proc_alu.sv
//----------------------------------------------------------
// execute-stage alu with the equality compare used by bne
//----------------------------------------------------------

`timescale 1ns/1ps

module proc_alu (
  input  proc_pkg::word_t   op_a,
  input  proc_pkg::word_t   op_b,
  input  proc_pkg::alu_fn_e fn,
  output proc_pkg::word_t   result,
  output logic              eq
);

  // shift amount is the low five bits of operand 2
  logic [4:0] shamt;
  assign shamt = op_b[4:0];

  always_comb begin
    case (fn)
      proc_pkg::alu_add:  result = op_a + op_b;
      proc_pkg::alu_sub:  result = op_a - op_b;
      proc_pkg::alu_and:  result = op_a & op_b;
      proc_pkg::alu_or:   result = op_a | op_b;
      proc_pkg::alu_xor:  result = op_a ^ op_b;
      proc_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      proc_pkg::alu_sltu: result = {31'd0, op_a < op_b};
      proc_pkg::alu_sra:  result = $signed(op_a) >>> shamt;
      proc_pkg::alu_srl:  result = op_a >> shamt;
      proc_pkg::alu_sll:  result = op_a << shamt;
      // csrr passes the manager word on operand 2
      default:            result = op_b;
    endcase
  end

  assign eq = (op_a == op_b);

endmodule

// File: verilog/proc_pkg.sv
//----------------------------------------------------------
// shared types and constants for the five-stage processor
// every module refers to these by proc_pkg:: scoped names
//----------------------------------------------------------

package proc_pkg;

  //----------------------------------------------------------
  // widths
  //----------------------------------------------------------

  // data, instruction and address word
  typedef logic [31:0] word_t;

  // register specifier
  typedef logic [4:0] reg_addr_t;

  // csr number
  typedef logic [11:0] csr_addr_t;

  //----------------------------------------------------------
  // select codes and opcodes
  //----------------------------------------------------------

  // alu function, cp1 passes operand 2 straight through
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sra,
    alu_srl,
    alu_sll,
    alu_cp1
  } alu_fn_e;

  // operand 2 source in D
  typedef enum logic [1:0] {
    op2_rf,
    op2_imm,
    op2_mngr
  } op2_sel_e;

  // next fetch address
  typedef enum logic {
    pc_plus4,
    pc_br
  } pc_sel_e;

  // only bne is kept
  typedef enum logic {
    br_none,
    br_bne
  } br_type_e;

  // manager channels seen as csrs
  localparam csr_addr_t csr_proc2mngr = 12'h7c0;
  localparam csr_addr_t csr_mngr2proc = 12'hfc0;

  //----------------------------------------------------------
  // control to datapath
  //----------------------------------------------------------

  typedef struct packed {
    logic      reg_en_f;
    logic      reg_en_d;
    logic      reg_en_x;
    logic      reg_en_m;
    logic      reg_en_w;
    pc_sel_e   pc_sel;
    op2_sel_e  op2_sel_d;
    alu_fn_e   alu_fn_x;
    logic      rf_wen_w;
    reg_addr_t rf_waddr_w;
  } ctrl_sig_t;

  // datapath back to control
  typedef struct packed {
    word_t inst_d;
    logic  br_cond_eq_x;
  } stat_sig_t;

endpackage
